// File: src.f
ntm_oneplus_pkg.sv
ntm_matrix_pkg.sv
ntm_matrix_index_decode.sv
ntm_oneplus_execute.sv
ntm_oneplus_result.sv
ntm_matrix_oneplus_function.sv
ntm_matrix_oneplus_assertions.sv
ntm_matrix_oneplus_tb.sv

// File: Bender.yml
package:
  name: ntm_matrix_oneplus

sources:
  - ntm_oneplus_pkg.sv
  - ntm_matrix_pkg.sv
  - ntm_matrix_index_decode.sv
  - ntm_oneplus_execute.sv
  - ntm_oneplus_result.sv
  - ntm_matrix_oneplus_function.sv
  - target: simulation
    files:
      - ntm_matrix_oneplus_assertions.sv
      - ntm_matrix_oneplus_tb.sv

// File: ntm_matrix_oneplus_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_matrix_oneplus_tb
  import ntm_oneplus_pkg::*;
();

  //////////////////////////////////////////////////////////////////////
  // Test table with fixed words and reference data
  //////////////////////////////////////////////////////////////////////

  typedef struct {
    string name;
    int    rows;
    int    cols;
    bit    use_lcg;
    bit    wrong_strobes;  // idle strobes then a wrong kind before each element
    int    gap;            // idle cycles after each element
  } test_t;

  localparam int num_tests = 5;

  test_t       tests [num_tests];
  // 0, -32768, 32767, 1.0, -2.5, 7.0
  logic [15:0] fixed_in [6] = '{16'h0000, 16'h8000, 16'h7fff, 16'h0100, 16'hfd80, 16'h0700};
  logic [15:0] fixed_exp [6] = '{16'd433, 16'd256, 16'd32767, 16'd592, 16'd288, 16'd2048};
  // round(256 * ln(1 + e^-k))
  int          softplus_corr [8] = '{177, 80, 32, 12, 5, 2, 1, 0};

  logic                  CLK = 1'b0;
  logic                  RST;
  logic                  START;
  logic                  DATA_IN_I_ENABLE;
  logic                  DATA_IN_J_ENABLE;
  logic [7:0]            SIZE_I_IN;
  logic [7:0]            SIZE_J_IN;
  logic [word_width-1:0] DATA_IN;
  logic                  READY;
  logic                  DATA_OUT_I_ENABLE;
  logic                  DATA_OUT_J_ENABLE;
  logic [word_width-1:0] DATA_OUT;

  // Expected results in arrival order
  oneplus_word_t exp_word [$];
  logic [2:0]    exp_flags [$];  // {row end, element, matrix end}
  int            exp_cycle [$];

  // Last word delivered, zero out of reset
  oneplus_word_t held_word = '0;

  int            cyc = 0;
  int            watchdog_cycles;
  bit            checking = 1'b0;
  string         cur_name = "reset";
  logic [31:0]   lcg_state = 32'h92d4_2a48;
  logic [2:0]    exp_strobes;

  ntm_matrix_oneplus_function #(
    .CONTROL_SIZE(8)
  ) dut0 (
    .CLK(CLK), .RST(RST), .START(START), .READY(READY),
    .DATA_IN_I_ENABLE(DATA_IN_I_ENABLE), .DATA_IN_J_ENABLE(DATA_IN_J_ENABLE),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE), .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
    .SIZE_I_IN(SIZE_I_IN), .SIZE_J_IN(SIZE_J_IN), .DATA_IN(DATA_IN), .DATA_OUT(DATA_OUT)
  );

  always #4 CLK = ~CLK;
  always @(posedge CLK) cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // max(x,0) + corr(k) + 1.0 clipped at +32767
  function automatic oneplus_word_t oneplus_ref(input oneplus_word_t x);
    int            v;
    int            mag;
    int            k;
    int            sum;
    oneplus_word_t y;
    v   = x.raw;
    mag = (v < 0) ? -v : v;
    if (mag > 32767) mag = 32767;
    k   = (mag / 256 > 7) ? 7 : mag / 256;
    sum = ((v > 0) ? v : 0) + softplus_corr[k] + 256;
    y.raw = (sum > 32767) ? 16'sd32767 : sum[15:0];
    return y;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string what, input oneplus_word_t exp, input oneplus_word_t act);
    if (exp !== act)
      report_failure($sformatf("** Error %s %s: expected %0d, actual %0d",
                               cur_name, what, exp.raw, act.raw));
  endtask

  task automatic check_strobes(input string what, input logic [2:0] exp, input logic [2:0] act);
    if (exp !== act)
      report_failure($sformatf("** Error %s %s: expected %b, actual %b",
                               cur_name, what, exp, act));
  endtask

  // Strobes stay low unless a result is due this cycle
  always @(negedge CLK) begin
    if (checking) begin
      exp_strobes = 3'b000;
      if (exp_cycle.size() > 0 && exp_cycle[0] == cyc) exp_strobes = exp_flags[0];
      check_strobes("I/J/READY", exp_strobes, {DATA_OUT_I_ENABLE, DATA_OUT_J_ENABLE, READY});
      if (exp_strobes[1]) begin
        check_word("DATA_OUT", exp_word[0], DATA_OUT);
        held_word = exp_word[0];
        exp_word.delete(0);
        exp_flags.delete(0);
        exp_cycle.delete(0);
      end else begin
        // Word holds between results
        check_word("DATA_OUT hold", held_word, DATA_OUT);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the edge and strobes drop by default
  task automatic next_cycle();
    @(posedge CLK);
    #1;
    START            = 1'b0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
  endtask

  task automatic run_test(input int t);
    int            n;
    logic          last_col;
    oneplus_word_t word;
    oneplus_word_t expect_word;
    cur_name = tests[t].name;
    if (tests[t].wrong_strobes) begin
      // Strobes while decode is idle produce nothing
      next_cycle();
      DATA_IN_I_ENABLE = 1'b1;
      DATA_IN          = 16'h7abc;
      next_cycle();
      DATA_IN_J_ENABLE = 1'b1;
    end
    next_cycle();
    START     = 1'b1;
    SIZE_I_IN = tests[t].rows[7:0];
    SIZE_J_IN = tests[t].cols[7:0];
    for (int r = 0; r < tests[t].rows; r++) begin
      for (int c = 0; c < tests[t].cols; c++) begin
        if (tests[t].wrong_strobes) begin
          // J where I is due and I where J is due
          next_cycle();
          DATA_IN          = 16'h7abc;
          DATA_IN_J_ENABLE = (c == 0);
          DATA_IN_I_ENABLE = (c != 0);
        end
        next_cycle();
        n = r * tests[t].cols + c;
        if (tests[t].use_lcg) begin
          lcg_state   = lcg_next(lcg_state);
          word.raw    = lcg_state[31:16];
          expect_word = oneplus_ref(word);
        end else begin
          word.raw        = fixed_in[n % 6];
          expect_word.raw = fixed_exp[n % 6];
        end
        DATA_IN          = word.raw;
        DATA_IN_I_ENABLE = (c == 0);
        DATA_IN_J_ENABLE = (c != 0);
        last_col = (c == tests[t].cols - 1);
        exp_word.push_back(expect_word);
        exp_flags.push_back({last_col, 1'b1, last_col && (r == tests[t].rows - 1)});
        // Strobe in cycle n gives the result in cycle n+4
        exp_cycle.push_back(cyc + 4);
        repeat (tests[t].gap) next_cycle();
      end
    end
    next_cycle();
    wait (exp_word.size() == 0);
  endtask

  initial begin
    tests[0] = '{"fixed_words", 1, 6, 1'b0, 1'b0, 0};
    tests[1] = '{"matrix_3x4", 3, 4, 1'b1, 1'b0, 1};
    tests[2] = '{"wrong_strobes", 2, 3, 1'b0, 1'b1, 0};
    tests[3] = '{"single_1x1", 1, 1, 1'b0, 1'b0, 0};
    tests[4] = '{"lcg_5x6", 5, 6, 1'b1, 1'b0, 0};
    RST              = 1'b1;
    START            = 1'b0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    SIZE_I_IN        = '0;
    SIZE_J_IN        = '0;
    DATA_IN          = '0;
    repeat (3) @(posedge CLK);
    #1;
    RST      = 1'b0;
    checking = 1'b1;
    check_word("DATA_OUT after reset", '0, DATA_OUT);
    for (int t = 0; t < num_tests; t++) run_test(t);
    repeat (4) next_cycle();
    if (dut0.oneplus_result.result_checks.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Limit from the element counts plus room for start and drain
  initial begin
    #1;
    watchdog_cycles = 64;
    for (int t = 0; t < num_tests; t++)
      watchdog_cycles += tests[t].rows * tests[t].cols * (tests[t].gap + 1)
                         * (tests[t].wrong_strobes ? 2 : 1) + 16;
    #(watchdog_cycles * 8);
    report_failure("Timeout, the results did not all arrive before the watchdog limit");
  end

endmodule

`default_nettype wire

// File: ntm_matrix_oneplus_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_matrix_oneplus_assertions (
  input logic CLK,
  input logic RST,
  input logic DATA_OUT_I_ENABLE,
  input logic DATA_OUT_J_ENABLE,
  input logic READY
);

  //////////////////////////////////////////////////////////////////////
  // Strobe rules at the result stage
  //////////////////////////////////////////////////////////////////////

  // Failures seen so far
  int fail_count = 0;

  // Row end only on an element
  row_end_on_element: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_I_ENABLE |-> DATA_OUT_J_ENABLE)
    else begin
      $error("row end strobe without element strobe");
      fail_count++;
    end

  // Matrix end is also a row end
  ready_on_row_end: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_I_ENABLE)
    else begin
      $error("READY without row end strobe");
      fail_count++;
    end

  // All quiet in reset
  quiet_in_reset: assert property (@(posedge CLK)
    RST |-> !(DATA_OUT_I_ENABLE || DATA_OUT_J_ENABLE || READY))
    else begin
      $error("output strobe high during reset");
      fail_count++;
    end

endmodule

bind ntm_oneplus_result ntm_matrix_oneplus_assertions result_checks (.*);

`default_nettype wire

// File: ntm_matrix_oneplus_function.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_matrix_oneplus_function
  import ntm_oneplus_pkg::*;
  import ntm_matrix_pkg::*;
#(
  parameter int CONTROL_SIZE = index_width_default
) (
  input  logic                    CLK,
  input  logic                    RST,

  // Control
  input  logic                    START,
  output logic                    READY,

  input  logic                    DATA_IN_I_ENABLE,
  input  logic                    DATA_IN_J_ENABLE,
  output logic                    DATA_OUT_I_ENABLE,
  output logic                    DATA_OUT_J_ENABLE,

  // Data
  input  logic [CONTROL_SIZE-1:0] SIZE_I_IN,
  input  logic [CONTROL_SIZE-1:0] SIZE_J_IN,
  input  logic [word_width-1:0]   DATA_IN,
  output logic [word_width-1:0]   DATA_OUT
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Decode to execute
  logic          in_valid;
  oneplus_word_t in_word;
  element_tag_t  in_tag;

  // Execute to result
  logic          out_valid;
  oneplus_word_t out_word;
  element_tag_t  out_tag;

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  // Index control, one cycle
  ntm_matrix_index_decode #(
    .CONTROL_SIZE(CONTROL_SIZE)
  ) index_decode (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .DATA_IN_I_ENABLE(DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE(DATA_IN_J_ENABLE),
    .SIZE_I_IN       (SIZE_I_IN),
    .SIZE_J_IN       (SIZE_J_IN),
    .DATA_IN         (DATA_IN),
    .in_valid        (in_valid),
    .in_word         (in_word),
    .in_tag          (in_tag)
  );

  // Oneplus pipeline, two cycles
  ntm_oneplus_execute oneplus_execute (
    .CLK      (CLK),
    .RST      (RST),
    .in_valid (in_valid),
    .in_word  (in_word),
    .in_tag   (in_tag),
    .out_valid(out_valid),
    .out_word (out_word),
    .out_tag  (out_tag)
  );

  // Output strobes, one cycle
  ntm_oneplus_result oneplus_result (
    .CLK              (CLK),
    .RST              (RST),
    .out_valid        (out_valid),
    .out_word         (out_word),
    .out_tag          (out_tag),
    .DATA_OUT         (DATA_OUT),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
    .READY            (READY)
  );

endmodule

`default_nettype wire

// File: ntm_oneplus_result.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_oneplus_result
  import ntm_oneplus_pkg::*;
  import ntm_matrix_pkg::*;
(
  input  logic                  CLK,
  input  logic                  RST,

  // From execute
  input  logic                  out_valid,
  input  oneplus_word_t         out_word,
  input  element_tag_t          out_tag,

  // Matrix outputs
  output logic [word_width-1:0] DATA_OUT,
  output logic                  DATA_OUT_I_ENABLE,
  output logic                  DATA_OUT_J_ENABLE,
  output logic                  READY
);

  //////////////////////////////////////////////////////////////////////
  // Output register and strobes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT          <= '0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      READY             <= 1'b0;
    end else begin
      // Every element
      DATA_OUT_J_ENABLE <= out_valid;

      // Row end, together with J
      DATA_OUT_I_ENABLE <= out_valid && out_tag.row_last;

      // Matrix end, one pulse
      READY             <= out_valid && out_tag.matrix_last;

      // Word held between results
      if (out_valid) begin
        DATA_OUT <= out_word.raw;
      end
    end
  end

endmodule

`default_nettype wire

// File: ntm_oneplus_execute.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_oneplus_execute
  import ntm_oneplus_pkg::*;
  import ntm_matrix_pkg::*;
(
  input  logic          CLK,
  input  logic          RST,

  // From decode
  input  logic          in_valid,
  input  oneplus_word_t in_word,
  input  element_tag_t  in_tag,

  // To result, two cycles later
  output logic          out_valid,
  output oneplus_word_t out_word,
  output element_tag_t  out_tag
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Stage 1 combinational
  oneplus_word_t       pos_word;
  oneplus_word_t       mag_word;
  logic [2:0]          corr_index;

  // Stage 1 registers
  logic                s1_valid;
  element_tag_t        s1_tag;
  oneplus_word_t       s1_pos;
  logic [7:0]          s1_corr;

  // Stage 2 combinational, one spare bit for the carry
  logic [word_width:0] sum_wide;
  oneplus_word_t       sat_word;

  //////////////////////////////////////////////////////////////////////
  // Stage 1, max(x,0) and table lookup
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Positive part
    pos_word.raw = in_word.fields.sign ? '0 : in_word.raw;

    // |x|, most negative word taken as largest positive
    if (!in_word.fields.sign) begin
      mag_word.raw = in_word.raw;
    end else if (in_word.raw == 16'sh8000) begin
      mag_word.raw = max_word;
    end else begin
      mag_word.raw = -in_word.raw;
    end

    // Integer part clamped to 7
    if (mag_word.fields.int_part > 7'd7) begin
      corr_index = 3'd7;
    end else begin
      corr_index = mag_word.fields.int_part[2:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    s1_tag  <= in_tag;
    s1_pos  <= pos_word;
    s1_corr <= corr_table[corr_index];
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2, add and saturate
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sum_wide = {1'b0, s1_pos.raw} + {{(word_width-7){1'b0}}, s1_corr}
             + {1'b0, one_fixed};
    // Clip to +32767
    if (sum_wide > {1'b0, max_word}) begin
      sat_word.raw = max_word;
    end else begin
      sat_word.raw = sum_wide[word_width-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    out_tag  <= s1_tag;
    out_word <= sat_word;
  end

endmodule

`default_nettype wire

// File: ntm_matrix_index_decode.sv
`timescale 1ns/100ps
`default_nettype none

module ntm_matrix_index_decode
  import ntm_oneplus_pkg::*;
  import ntm_matrix_pkg::*;
#(
  parameter int CONTROL_SIZE = index_width_default
) (
  input  logic                    CLK,
  input  logic                    RST,

  // Control in
  input  logic                    START,
  input  logic                    DATA_IN_I_ENABLE,
  input  logic                    DATA_IN_J_ENABLE,

  // Sizes and data
  input  logic [CONTROL_SIZE-1:0] SIZE_I_IN,
  input  logic [CONTROL_SIZE-1:0] SIZE_J_IN,
  input  oneplus_word_t           DATA_IN,

  // Towards execute
  output logic                    in_valid,
  output oneplus_word_t           in_word,
  output element_tag_t            in_tag
);

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Idle (0) or active (1)
  logic                    active;

  // Sizes latched at START
  logic [CONTROL_SIZE-1:0] size_i;
  logic [CONTROL_SIZE-1:0] size_j;

  // Current position
  logic [CONTROL_SIZE-1:0] index_i;
  logic [CONTROL_SIZE-1:0] index_j;

  // Last index values
  logic [CONTROL_SIZE-1:0] last_i;
  logic [CONTROL_SIZE-1:0] last_j;

  logic                    accept;
  logic                    row_last;
  logic                    matrix_last;

  //////////////////////////////////////////////////////////////////////
  // Acceptance and position
  //////////////////////////////////////////////////////////////////////

  assign last_i = size_i - 1'b1;
  assign last_j = size_j - 1'b1;

  // I strobe opens a row, J strobe for the rest
  // Wrong kind or idle strobes are dropped
  assign accept = active &&
                  ((index_j == '0) ? DATA_IN_I_ENABLE : DATA_IN_J_ENABLE);

  assign row_last    = (index_j == last_j);
  assign matrix_last = row_last && (index_i == last_i);

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      active   <= 1'b0;
      size_i   <= '0;
      size_j   <= '0;
      index_i  <= '0;
      index_j  <= '0;
      in_valid <= 1'b0;
    end else begin
      in_valid <= accept;

      if (!active) begin
        // New matrix only from idle
        if (START) begin
          size_i  <= SIZE_I_IN;
          size_j  <= SIZE_J_IN;
          index_i <= '0;
          index_j <= '0;
          active  <= 1'b1;
        end
      end else if (accept) begin
        if (matrix_last) begin
          // Back to idle, results still draining
          active <= 1'b0;
        end
        // Step the indices
        if (row_last) begin
          index_j <= '0;
          index_i <= index_i + 1'b1;
        end else begin
          index_j <= index_j + 1'b1;
        end
      end
    end
  end

  // Word and tag, loaded on accept only
  always_ff @(posedge CLK) begin
    if (accept) begin
      in_word            <= DATA_IN;
      in_tag.row_last    <= row_last;
      in_tag.matrix_last <= matrix_last;
    end
  end

endmodule

`default_nettype wire

// File: ntm_matrix_pkg.sv
`default_nettype none

package ntm_matrix_pkg;

  //////////////////////////////////////////////////////////////////////
  // Matrix control
  //////////////////////////////////////////////////////////////////////

  // Default width of indices and sizes
  localparam int index_width_default = 8;

  // Position flags riding along with each element
  // Created in decode, delayed by execute, used by result
  typedef struct packed {
    logic row_last;     // last column of a row
    logic matrix_last;  // last element overall
  } element_tag_t;

endpackage

`default_nettype wire

// File: ntm_oneplus_pkg.sv
`default_nettype none

package ntm_oneplus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word format, Q7.8 signed
  //////////////////////////////////////////////////////////////////////

  localparam int word_width = 16;
  localparam int frac_bits  = 8;

  // Field view of one word
  typedef struct packed {
    logic                                sign;
    logic [word_width-frac_bits-2:0]     int_part;
    logic [frac_bits-1:0]                frac;
  } oneplus_fields_t;

  // Same word, read as a number or as fields
  typedef union packed {
    logic signed [word_width-1:0] raw;
    oneplus_fields_t              fields;
  } oneplus_word_t;

  //////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////

  // round(256 * ln(1 + e^-k)), k = 0..7
  localparam logic [7:0] corr_table [0:7] = '{
    8'd177,
    8'd80,
    8'd32,
    8'd12,
    8'd5,
    8'd2,
    8'd1,
    8'd0
  };

  // 1.0 in Q7.8
  localparam logic signed [word_width-1:0] one_fixed = 16'sd1 <<< frac_bits;

  // Saturation limit, largest positive word
  localparam logic signed [word_width-1:0] max_word = 16'sd32767;

endpackage

`default_nettype wire
